// File: files.f
twdl_cfg_pkg.sv
cordic_pkg.sv
twdl_step_div.sv
twdl_phase_acc.sv
cordic_rotator.sv
twiddle_gen.sv
tb_clkgen.sv
tb_twiddle_gen.sv

// File: Bender.yml
package:
  name: twiddle_gen

sources:
  # packages first, then the design from the leaves up
  - twdl_cfg_pkg.sv
  - cordic_pkg.sv
  - twdl_step_div.sv
  - twdl_phase_acc.sv
  - cordic_rotator.sv
  - twiddle_gen.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_twiddle_gen.sv

// File: tb_twiddle_gen.sv
// ----------------------------------------------------------------------
// testbench of the twiddle generator
// runs a table of configurations and checks every factor against a cos and -sin model
// ----------------------------------------------------------------------
`default_nettype none

module tb_twiddle_gen;
	timeunit 1ns;
	timeprecision 100ps;
	import twdl_cfg_pkg::*;

	localparam int AMPL = 16384;
	localparam int TOL = 6;
	localparam int N_ROWS = 11;
	localparam int HS_TIMEOUT = 200;
	localparam real PI = 3.14159265358979;

	// one configuration and the sample count its run must deliver
	typedef struct packed {
		logic [W_IN-1:0] n_points;
		logic [W_IN-1:0] run_len;
		logic [W_IN-1:0] exp_samples;
		logic            overlap;
	} row_t;

	logic       clk;
	logic       rst_n;
	logic       cfg_req;
	twdl_cfg_t  cfg;
	logic       cfg_ack;
	twdl_cplx_t dout;
	logic       dout_valid;
	twdl_mark_t dout_mark;

	row_t stim_table [N_ROWS];
	// rows acked but not yet fully seen on the output
	int   run_q [$];
	int   errors;
	int   checks;
	int   rows_done;
	// sample index inside the current output run
	int   k;
	logic req_seen;
	logic ack_q;
	logic aborted;
	int   hist_re [4096];
	int   hist_im [4096];

	tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(16)) u_clkgen (.clk(clk), .rst_n(rst_n));

	twiddle_gen #(.AMPL(AMPL), .N_ITER(16)) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_req    (cfg_req),
		.cfg        (cfg),
		.cfg_ack    (cfg_ack),
		.dout       (dout),
		.dout_valid (dout_valid),
		.dout_mark  (dout_mark)
	);

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// floor(idx * 2^20 / n) mod one turn
	function automatic longint exact_phase(input int n, input int idx);
		return ((longint'(idx) << W_PHASE) / n) % (longint'(1) << W_PHASE);
	endfunction

	function automatic int round_real(input real r);
		if (r >= 0.0)
			return $rtoi(r + 0.5);
		return -$rtoi(0.5 - r);
	endfunction

	function automatic real phase_angle(input int n, input int idx);
		return 2.0 * PI * real'(exact_phase(n, idx)) / real'(longint'(1) << W_PHASE);
	endfunction

	function automatic int expected_cos(input int n, input int idx);
		return round_real(AMPL * $cos(phase_angle(n, idx)));
	endfunction

	function automatic int expected_nsin(input int n, input int idx);
		return round_real(-AMPL * $sin(phase_angle(n, idx)));
	endfunction

	function automatic bit near(input int a, input int b);
		return (a - b <= TOL) && (b - a <= TOL);
	endfunction

	function automatic row_t make_row(input int n, input int len, input logic ov);
		row_t r;
		r.n_points = W_IN'(n);
		r.run_len = W_IN'(len);
		r.exp_samples = W_IN'(len);
		r.overlap = ov;
		return r;
	endfunction

	// checks one output sample for value, framing and the special points
	task automatic check_sample(input row_t r);
		int n;
		int re;
		int im;
		int exp_re;
		int exp_im;
		n = r.n_points;
		re = $signed(dout.re);
		im = $signed(dout.im);
		exp_re = expected_cos(n, k);
		exp_im = expected_nsin(n, k);
		hist_re[k] = re;
		hist_im[k] = im;
		checks++;
		assert (dout_mark.sop == (k == 0) && dout_mark.eop == (k == r.exp_samples - 1))
		else begin
			errors++;
			$display("framing wrong: sop/eop at sample %0d of n %0d, time %0t", k, n, $time);
		end
		checks++;
		assert (near(re, exp_re) && near(im, exp_im))
		else begin
			errors++;
			$display("mismatch at %0t: n %0d k %0d got (%0d, %0d) expected (%0d, %0d)",
				$time, n, k, re, im, exp_re, exp_im);
		end
		// quarter turn lands on (0, -AMPL) and half turn on (-AMPL, 0)
		if (n % 4 == 0 && (k == n / 4 || k == n / 2)) begin
			checks++;
			assert (k == n / 4 ? near(re, 0) && near(im, -AMPL)
				: near(re, -AMPL) && near(im, 0))
			else begin
				errors++;
				$display("mismatch at %0t: n %0d quarter point k %0d got (%0d, %0d)",
					$time, n, k, re, im);
			end
		end
		// past a full turn the sequence repeats
		if (k >= n) begin
			checks++;
			assert (near(re, hist_re[k-n]) && near(im, hist_im[k-n]))
			else begin
				errors++;
				$display("mismatch at %0t: n %0d k %0d differs from k %0d",
					$time, n, k, k - n);
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// output monitor
	// ----------------------------------------------------------------------
	always @(posedge clk) begin : monitor
		row_t r;
		if (rst_n) begin
			// quiet until the first request
			if (!req_seen) begin
				checks++;
				assert (!cfg_ack && !dout_valid)
				else begin
					errors++;
					$display("ack or valid seen before the first request at %0t", $time);
				end
			end
			if (cfg_ack && !ack_q) begin
				checks++;
				assert (cfg_req)
				else begin
					errors++;
					$display("ack rose without a request at %0t", $time);
				end
			end
			if (!cfg_ack && ack_q) begin
				checks++;
				assert (!cfg_req)
				else begin
					errors++;
					$display("ack fell while the request was still high at %0t", $time);
				end
			end
			// no sample may appear between runs
			if (dout_valid) begin
				checks++;
				assert (run_q.size() != 0)
				else begin
					errors++;
					$display("valid sample outside any run at %0t", $time);
				end
			end
			if (dout_valid && run_q.size() != 0) begin
				r = stim_table[run_q[0]];
				check_sample(r);
				if (k == r.exp_samples - 1) begin
					$display("row %0d n %0d len %0d: %0d samples, errors so far %0d",
						run_q[0], r.n_points, r.run_len, k + 1, errors);
					void'(run_q.pop_front());
					rows_done++;
					k = 0;
				end else begin
					k++;
				end
			end
		end
		ack_q = cfg_ack;
	end

	// ----------------------------------------------------------------------
	// configuration driver
	// ----------------------------------------------------------------------
	// four-phase handshake
	// ack_wait also covers a run still in flight
	task automatic do_handshake(input int row, input int ack_wait, output bit ok);
		int t;
		ok = 1'b0;
		cfg_req <= 1'b1;
		cfg.n_points <= stim_table[row].n_points;
		cfg.run_len <= stim_table[row].run_len;
		req_seen <= 1'b1;
		t = 0;
		while (!cfg_ack && t < ack_wait) begin
			@(posedge clk);
			t++;
		end
		if (!cfg_ack) begin
			$display("timeout: no ack for row %0d within %0d cycles", row, ack_wait);
			return;
		end
		// the previous run must be out before the new one is taken
		checks++;
		assert (run_q.size() == 0)
		else begin
			errors++;
			$display("row %0d acked before the previous run ended at %0t", row, $time);
		end
		run_q.push_back(row);
		cfg_req <= 1'b0;
		t = 0;
		while (cfg_ack && t < HS_TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (cfg_ack) begin
			$display("timeout: ack of row %0d never fell", row);
			return;
		end
		ok = 1'b1;
	endtask

	task automatic wait_runs_done(input int limit, output bit ok);
		int t;
		t = 0;
		while (run_q.size() != 0 && t < limit) begin
			@(posedge clk);
			t++;
		end
		ok = (run_q.size() == 0);
		if (!ok)
			$display("timeout: run did not finish within %0d cycles", limit);
	endtask

	initial begin : drive
		bit          ok;
		int          ack_wait;
		int          i;
		int          t;
		logic [31:0] lcg_state;
		cfg_req = 1'b0;
		cfg = '0;
		errors = 0;
		checks = 0;
		rows_done = 0;
		k = 0;
		req_seen = 1'b0;
		ack_q = 1'b0;
		aborted = 1'b0;
		stim_table[0] = make_row(1200, 1200, 1'b1);
		stim_table[1] = make_row(300, 16, 1'b0);
		stim_table[2] = make_row(4, 4, 1'b0);
		stim_table[3] = make_row(12, 30, 1'b0);
		stim_table[4] = make_row(1200, 7, 1'b0);
		lcg_state = 32'h5c5614f6;
		for (i = 5; i < N_ROWS; i++) begin
			lcg_state = lcg_next(lcg_state);
			t = 2 + int'(lcg_state[31:8] % 4094);
			lcg_state = lcg_next(lcg_state);
			stim_table[i] = make_row(t, 1 + int'(lcg_state[31:8] % 64), 1'b0);
		end
		t = 0;
		while (!rst_n && t < 100) begin
			@(posedge clk);
			t++;
		end
		if (!rst_n) begin
			$display("reset was never released");
			aborted = 1'b1;
		end
		// idle stretch while the monitor watches ack and valid stay low
		repeat (20) @(posedge clk);
		ack_wait = HS_TIMEOUT;
		for (i = 0; i < N_ROWS && !aborted; i++) begin
			do_handshake(i, ack_wait, ok);
			aborted = !ok;
			ack_wait = HS_TIMEOUT;
			if (ok && stim_table[i].overlap) begin
				// next request goes up while this run still streams
				ack_wait = HS_TIMEOUT + stim_table[i].run_len;
			end else if (ok) begin
				wait_runs_done(stim_table[i].run_len + 100, ok);
				aborted = !ok;
			end
		end
		repeat (30) @(posedge clk);
		$display("rows %0d of %0d, checks %0d, errors %0d", rows_done, N_ROWS, checks, errors);
		if (errors == 0 && !aborted && rows_done == N_ROWS)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// ----------------------------------------------------------------------
// testbench clock and synchronous reset, low for RST_CYCLES edges
// ----------------------------------------------------------------------
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// released on a rising edge like any other driven input
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: twiddle_gen.sv
// --------------------------------------------------------------------
// twiddle generator top, config handshake in and factor stream out
// --------------------------------------------------------------------
`default_nettype none

module twiddle_gen #(
	parameter int AMPL   = 16384,
	parameter int N_ITER = 16
) (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            cfg_req,
	input  wire twdl_cfg_pkg::twdl_cfg_t   cfg,
	output logic                           cfg_ack,
	output twdl_cfg_pkg::twdl_cplx_t       dout,
	output logic                           dout_valid,
	output twdl_cfg_pkg::twdl_mark_t       dout_mark
);
	import twdl_cfg_pkg::*;

	// divider to accumulator
	logic               start;
	logic               busy;
	twdl_step_t         step;
	logic [W_IN-1:0]    n_points;
	logic [W_IN-1:0]    run_len;

	// accumulator to rotator
	logic [W_PHASE-1:0] phase;
	logic               phase_valid;
	twdl_mark_t         mark;

	twdl_step_div u_step_div (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_req  (cfg_req),
		.cfg      (cfg),
		.busy     (busy),
		.cfg_ack  (cfg_ack),
		.start    (start),
		.step     (step),
		.n_points (n_points),
		.run_len  (run_len)
	);

	twdl_phase_acc u_phase_acc (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.step        (step),
		.n_points    (n_points),
		.run_len     (run_len),
		.busy        (busy),
		.phase       (phase),
		.phase_valid (phase_valid),
		.mark        (mark)
	);

	cordic_rotator #(
		.AMPL   (AMPL),
		.N_ITER (N_ITER)
	) u_rotator (
		.clk         (clk),
		.rst_n       (rst_n),
		.phase       (phase),
		.phase_valid (phase_valid),
		.mark        (mark),
		.dout        (dout),
		.dout_valid  (dout_valid),
		.dout_mark   (dout_mark)
	);

endmodule

`default_nettype wire

// File: cordic_rotator.sv
// --------------------------------------------------------------------
// pipelined CORDIC, phase in turns to (cos, -sin) scaled by AMPL
// fixed latency N_ITER+2, framing markers travel alongside
// --------------------------------------------------------------------
`default_nettype none

module cordic_rotator #(
	parameter int AMPL   = 16384,
	parameter int N_ITER = 16
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire [twdl_cfg_pkg::W_PHASE-1:0]   phase,
	input  wire                               phase_valid,
	input  wire twdl_cfg_pkg::twdl_mark_t     mark,
	output twdl_cfg_pkg::twdl_cplx_t          dout,
	output logic                              dout_valid,
	output twdl_cfg_pkg::twdl_mark_t          dout_mark
);
	import twdl_cfg_pkg::*;
	import cordic_pkg::*;

	// extra fraction bits against shift truncation
	localparam int GUARD = 3;
	// sign plus one bit of headroom above the output
	localparam int W_X = W_OUT + GUARD + 2;
	localparam int LAT = N_ITER + 2;
	// start magnitude with 1/K folded in, so the result ends at AMPL
	localparam int X0_INT = (AMPL * int'(CORDIC_GAIN_INV)) >>> (16 - GUARD);
	localparam logic signed [W_X-1:0] X0 = W_X'(X0_INT);
	// half an output LSB
	localparam logic signed [W_X-1:0] RND = W_X'(1 << (GUARD - 1));

	logic signed [W_X-1:0]     x_pipe [N_ITER+1];
	logic signed [W_X-1:0]     y_pipe [N_ITER+1];
	// residual angle, signed turns
	logic signed [W_PHASE-1:0] z_pipe [N_ITER+1];
	logic [1:0]                quad;
	logic signed [W_X-1:0]     x_rnd;
	logic signed [W_X-1:0]     y_rnd;
	logic [LAT-1:0]            vld_sr;
	twdl_mark_t [LAT-1:0]      mark_sr;
	// between sop and eop on the output
	logic                      in_run;

	if (N_ITER < 1 || N_ITER > MAX_ITER) begin : g_bad_iter
		$error("cordic_rotator: N_ITER out of range 1 to MAX_ITER");
	end

	// --------------------------------------------------------------------
	// quadrant folding
	// --------------------------------------------------------------------
	assign quad = phase[W_PHASE-1 -: 2];

	// pre-rotate the start vector by quad quarter turns
	// residual stays in [0, 1/4) turn, inside the convergence range
	always_ff @(posedge clk) begin
		case (quad)
			2'd0: begin
				x_pipe[0] <= X0;
				y_pipe[0] <= '0;
			end
			2'd1: begin
				x_pipe[0] <= '0;
				y_pipe[0] <= X0;
			end
			2'd2: begin
				x_pipe[0] <= -X0;
				y_pipe[0] <= '0;
			end
			default: begin
				x_pipe[0] <= '0;
				y_pipe[0] <= -X0;
			end
		endcase
		z_pipe[0] <= {2'b00, phase[W_PHASE-3:0]};
	end

	// --------------------------------------------------------------------
	// rotation stages
	// --------------------------------------------------------------------
	for (genvar i = 0; i < N_ITER; i++) begin : g_stage
		always_ff @(posedge clk) begin
			// turn toward zero residual
			if (!z_pipe[i][W_PHASE-1]) begin
				x_pipe[i+1] <= x_pipe[i] - (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] + (x_pipe[i] >>> i);
				z_pipe[i+1] <= z_pipe[i] - $signed(CORDIC_ATAN[i]);
			end else begin
				x_pipe[i+1] <= x_pipe[i] + (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] - (x_pipe[i] >>> i);
				z_pipe[i+1] <= z_pipe[i] + $signed(CORDIC_ATAN[i]);
			end
		end
	end

	// --------------------------------------------------------------------
	// output stage
	// --------------------------------------------------------------------
	// round half up, then drop guard bits
	assign x_rnd = x_pipe[N_ITER] + RND;
	// negated sine for the forward transform
	assign y_rnd = RND - y_pipe[N_ITER];

	always_ff @(posedge clk) begin
		dout.re <= x_rnd[GUARD +: W_OUT];
		dout.im <= y_rnd[GUARD +: W_OUT];
	end

	// valid and markers, one slot per pipeline stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_sr  <= '0;
			mark_sr <= '0;
		end else begin
			vld_sr  <= {vld_sr[LAT-2:0], phase_valid};
			mark_sr <= {mark_sr[LAT-2:0], mark};
		end
	end

	assign dout_valid = vld_sr[LAT-1];
	assign dout_mark = mark_sr[LAT-1];

	// run tracking on the output side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_run <= 1'b0;
		end else if (dout_valid) begin
			in_run <= (in_run || dout_mark.sop) && !dout_mark.eop;
		end
	end

	// every run that ends must have been opened
	a_eop_after_sop: assert property (@(posedge clk) disable iff (!rst_n)
		dout_valid && dout_mark.eop |-> in_run || dout_mark.sop);

endmodule

`default_nettype wire

// File: twdl_phase_acc.sv
// --------------------------------------------------------------------
// exact phase of sample k, floor(k * 2^W_PHASE / N) mod one turn
// one sample per cycle for run_len cycles after start
// --------------------------------------------------------------------
`default_nettype none

module twdl_phase_acc (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               start,
	input  wire twdl_cfg_pkg::twdl_step_t     step,
	input  wire [twdl_cfg_pkg::W_IN-1:0]      n_points,
	input  wire [twdl_cfg_pkg::W_IN-1:0]      run_len,
	output logic                              busy,
	output logic [twdl_cfg_pkg::W_PHASE-1:0]  phase,
	output logic                              phase_valid,
	output twdl_cfg_pkg::twdl_mark_t          mark
);
	import twdl_cfg_pkg::*;

	// index k of the sample on the output
	logic [W_IN-1:0]    cnt;
	// fractional part of k*2^W_PHASE/N, in units of 1/N
	logic [W_IN-1:0]    rem;
	logic [W_IN:0]      rem_sum;
	logic [W_IN:0]      rem_diff;
	logic               carry;
	logic [W_IN-1:0]    rem_next;
	logic [W_PHASE-1:0] phase_next;
	logic               next_last;

	// --------------------------------------------------------------------
	// remainder carry
	// --------------------------------------------------------------------
	// both terms below n_points, so the sum needs one extra bit
	assign rem_sum = {1'b0, rem} + {1'b0, step.rem};
	assign rem_diff = rem_sum - {1'b0, n_points};
	assign carry = (rem_sum >= {1'b0, n_points});
	assign rem_next = carry ? rem_diff[W_IN-1:0] : rem_sum[W_IN-1:0];

	// wraps modulo one turn by width
	assign phase_next = phase + step.quot + W_PHASE'(carry);

	// sample k+1 is the last one of the run
	assign next_last = (cnt + 1'b1) == (run_len - 1'b1);

	// covers the start cycle too, so no request slips in
	assign busy = start | phase_valid;

	// --------------------------------------------------------------------
	// run control and framing
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase_valid <= 1'b0;
			mark        <= '0;
			cnt         <= '0;
		end else if (start) begin
			phase_valid <= 1'b1;
			cnt         <= '0;
			mark.sop    <= 1'b1;
			// a single-sample run is sop and eop at once
			mark.eop    <= (run_len == W_IN'(1));
		end else if (phase_valid) begin
			phase_valid <= !mark.eop;
			cnt         <= cnt + 1'b1;
			mark.sop    <= 1'b0;
			mark.eop    <= !mark.eop && next_last;
		end
	end

	// accumulator datapath
	always_ff @(posedge clk) begin
		if (start) begin
			phase <= '0;
			rem   <= '0;
		end else if (phase_valid) begin
			phase <= phase_next;
			rem   <= rem_next;
		end
	end

	// holds as long as the divider hands over a proper remainder
	a_rem_bound: assert property (@(posedge clk) disable iff (!rst_n)
		phase_valid |-> rem < n_points);

endmodule

`default_nettype wire

// File: twdl_step_div.sv
// --------------------------------------------------------------------
// configuration slave, divides one turn by n_points, then starts a run
// --------------------------------------------------------------------
`default_nettype none

module twdl_step_div (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            cfg_req,
	input  wire twdl_cfg_pkg::twdl_cfg_t   cfg,
	input  wire                            busy,
	output logic                           cfg_ack,
	output logic                           start,
	output twdl_cfg_pkg::twdl_step_t       step,
	output logic [twdl_cfg_pkg::W_IN-1:0]  n_points,
	output logic [twdl_cfg_pkg::W_IN-1:0]  run_len
);
	import twdl_cfg_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_DIV, S_ACK} state_t;

	// W_PHASE+1 quotient bits plus one handoff cycle
	localparam int W_CNT = $clog2(W_PHASE + 2);

	state_t             state;
	logic [W_CNT-1:0]   cnt;
	logic [W_PHASE-1:0] quot;
	logic [W_IN-1:0]    rem;
	logic [W_IN:0]      trial;
	logic [W_IN:0]      diff;
	logic               accept;
	logic               last;

	// a request waits here while a run is still going
	assign accept = (state == S_IDLE) && cfg_req && !busy;
	assign last = (cnt == W_CNT'(W_PHASE + 1));

	// next partial remainder
	// only the leading dividend bit of 2^W_PHASE is set
	assign trial = {rem, (cnt == '0)};
	assign diff = trial - {1'b0, n_points};

	assign step = {quot, rem};

	// --------------------------------------------------------------------
	// handshake FSM
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			cnt     <= '0;
			cfg_ack <= 1'b0;
			start   <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_DIV;
						cnt   <= '0;
					end
				end
				S_DIV: begin
					cnt <= cnt + 1'b1;
					// step ready, launch run and answer together
					if (last) begin
						state   <= S_ACK;
						start   <= 1'b1;
						cfg_ack <= 1'b1;
					end
				end
				S_ACK: begin
					if (!cfg_req) begin
						state   <= S_IDLE;
						cfg_ack <= 1'b0;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// --------------------------------------------------------------------
	// restoring divider, one quotient bit per cycle
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			n_points <= cfg.n_points;
			run_len  <= cfg.run_len;
			quot     <= '0;
			rem      <= '0;
		end else if (state == S_DIV && !last) begin
			if (trial >= {1'b0, n_points}) begin
				rem  <= diff[W_IN-1:0];
				quot <= {quot[W_PHASE-2:0], 1'b1};
			end else begin
				rem  <= trial[W_IN-1:0];
				quot <= {quot[W_PHASE-2:0], 1'b0};
			end
		end
	end

	// the master must offer a usable configuration
	a_cfg_legal: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (cfg.n_points >= W_IN'(2)) && (cfg.run_len != '0));

	// ack only answers a pending request
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> cfg_req);

endmodule

`default_nettype wire

// File: cordic_pkg.sv
// --------------------------------------------------------------------
// constants of the phase-to-vector CORDIC rotator
// --------------------------------------------------------------------
`default_nettype none

package cordic_pkg;

	// table depth, upper bound for the iteration count
	localparam int MAX_ITER = 20;

	// atan(2^-i) in units of 2^-W_PHASE turns
	// entry 0 is one eighth of a turn
	localparam logic [twdl_cfg_pkg::W_PHASE-1:0] CORDIC_ATAN [MAX_ITER] = '{
		131072,
		77376,
		40884,
		20753,
		10417,
		5213,
		2607,
		1304,
		652,
		326,
		163,
		81,
		41,
		20,
		10,
		5,
		3,
		1,
		1,
		0
	};

	// 1/1.6468 in Q16
	// undoes the growth of the rotation stages
	localparam logic [15:0] CORDIC_GAIN_INV = 16'd39796;

endpackage

`default_nettype wire

// File: twdl_cfg_pkg.sv
// --------------------------------------------------------------------
// widths and stream types of the twiddle generator
// modules import it in the body and use scoped names in the port list
// --------------------------------------------------------------------
`default_nettype none

package twdl_cfg_pkg;

	// width of n_points and run_len
	localparam int W_IN = 12;
	// one full turn is 2^W_PHASE
	localparam int W_PHASE = 20;
	// signed output component
	localparam int W_OUT = 16;

	// one configuration, held stable while cfg_req is high
	typedef struct packed {
		logic [W_IN-1:0] n_points;
		logic [W_IN-1:0] run_len;
	} twdl_cfg_t;

	// phase step 2^W_PHASE / n_points
	// quot is added every sample, rem feeds the carry accumulator
	typedef struct packed {
		logic [W_PHASE-1:0] quot;
		logic [W_IN-1:0]    rem;
	} twdl_step_t;

	// run framing on the sample stream
	typedef struct packed {
		logic sop;
		logic eop;
	} twdl_mark_t;

	// complex factor, re holds cos and im holds -sin
	typedef struct packed {
		logic signed [W_OUT-1:0] re;
		logic signed [W_OUT-1:0] im;
	} twdl_cplx_t;

endpackage

`default_nettype wire
